/* Makefile */
TOP := vdma_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing -Wno-fatal -f compile.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

/* compile.f */
+incdir+logic
+incdir+dv
logic/vdma_pkg.sv
logic/vdma_ctrl_regs.sv
logic/video_timing_gen.sv
logic/stream_in_packer.sv
logic/beat_fifo.sv
logic/stream_out_aligner.sv
logic/vdma_stream_top.sv
dv/vdma_tb.sv

/* dv/vdma_tb_checks.svh */
// Included inside vdma_tb. Uses its clock, APB wires and CLK_PERIOD. The first error ends the run
//////////////////////////////////////////////////////////////////////
// Failure exit

task automatic end_with_failure();
	$display("SOME TESTS FAILED");
	$fatal(1, "run stopped at %0t ns", $time);
endtask

//////////////////////////////////////////////////////////////////////
// Typed compares, one per kind of result

task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
	if (act !== exp)
	begin
		$display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		end_with_failure();
	end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
	if (act !== exp)
	begin
		$display("Mismatch at %0t ns: %s expected %b, got %b", $time, name, exp, act);
		end_with_failure();
	end
endtask

task automatic check_pixels(input string name, input vdma_pkg::pixel_group_t exp,
	input vdma_pkg::pixel_group_t act);
	if (act !== exp)
	begin
		$display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		end_with_failure();
	end
endtask

//////////////////////////////////////////////////////////////////////
// APB accesses, setup then access phase, sampled mid access phase

task automatic start_access(input logic [15:0] addr, input logic write, input logic [31:0] data);
	@(negedge io_systemClk);
	apb_req.paddr   = addr;
	apb_req.pwrite  = write;
	apb_req.pwdata  = data;
	apb_req.psel    = 1'b1;
	apb_req.penable = 1'b0;
	@(negedge io_systemClk);
	apb_req.penable = 1'b1;
	#(CLK_PERIOD / 4);
endtask

// Access completes at the rising edge before this falling edge
task automatic release_bus();
	@(negedge io_systemClk);
	apb_req.psel    = 1'b0;
	apb_req.penable = 1'b0;
	apb_req.pwrite  = 1'b0;
	apb_req.pwdata  = '0;
endtask

task automatic write_reg(input logic [15:0] addr, input logic [31:0] data, input logic exp_err);
	start_access(addr, 1'b1, data);
	check_bit("pready", 1'b1, apb_rsp.pready);
	check_bit("pslverr", exp_err, apb_rsp.pslverr);
	release_bus();
endtask

task automatic read_reg(input logic [15:0] addr, input logic [31:0] exp, input logic exp_err);
	start_access(addr, 1'b0, 32'd0);
	check_bit("pready", 1'b1, apb_rsp.pready);
	check_bit("pslverr", exp_err, apb_rsp.pslverr);
	check_word("prdata", exp, apb_rsp.prdata);
	release_bus();
endtask

/* dv/vdma_tb.sv */
// Stops at the first error. Camera frames are 4 lines of 4 beats and the buffer holds one frame
`timescale 1ns/1ps
`include "vdma_macros.svh"

module vdma_tb;

	localparam int CLK_PERIOD  = 20;
	localparam int LINE_CLKS   = `VDMA_H_SYNC + `VDMA_H_BP + `VDMA_H_ACTIVE + `VDMA_H_FP;
	localparam int FRAME_LINES = `VDMA_V_SYNC + `VDMA_V_BP + `VDMA_V_ACTIVE + `VDMA_V_FP;
	localparam int FRAME_CLKS  = LINE_CLKS * FRAME_LINES;
	localparam int H_DE_FIRST  = `VDMA_H_SYNC + `VDMA_H_BP;
	localparam int V_DE_FIRST  = `VDMA_V_SYNC + `VDMA_V_BP;

	typedef enum {APB_WR, APB_RD, CAM_FRAMES, IDLE_FRAMES} op_t;

	// For frame rows data is the frame count, for idle rows exp is the groups still pending
	typedef struct {
		op_t         op;
		logic [15:0] offset;
		logic [31:0] data;
		logic [31:0] exp;
		logic        exp_err;
		logic        exp_irq;
	} row_t;

	logic               io_systemClk;
	logic               arst_n;
	vdma_pkg::apb_req_t apb_req;
	vdma_pkg::apb_rsp_t apb_rsp;
	vdma_pkg::video_t   cam;
	vdma_pkg::video_t   disp;
	logic               dma_irq;

	row_t                   rows[$];
	vdma_pkg::pixel_group_t exp_q[$];
	logic                   rows_loaded;
	int unsigned            clks_since_reset;
	vdma_pkg::video_t       sync_exp;

	`include "vdma_tb_checks.svh"

	vdma_stream_top UUT (
		.io_systemClk (io_systemClk),
		.arst_n       (arst_n),
		.apb_req      (apb_req),
		.apb_rsp      (apb_rsp),
		.cam          (cam),
		.disp         (disp),
		.dma_irq      (dma_irq)
	);

	always #(CLK_PERIOD / 2) io_systemClk = ~io_systemClk;

	// Rising edges seen since reset was released
	always @(posedge io_systemClk)
	begin
		if (!arst_n)
			clks_since_reset <= 0;
		else
			clks_since_reset <= clks_since_reset + 1;
	end

	//////////////////////////////////////////////////////////////////////
	// Camera frame driver

	function automatic vdma_pkg::pixel_group_t random_group();
		vdma_pkg::pixel_group_t g;
		g = vdma_pkg::pixel_group_t'($urandom());
		// The monitor treats black as no data
		if (g == '0)
			g.rd_11 = 8'h01;
		return g;
	endfunction

	task automatic drive_cam(input logic de, input logic hs, input logic vs,
		input vdma_pkg::pixel_group_t pix);
		@(negedge io_systemClk);
		cam.de  = de;
		cam.hs  = hs;
		cam.vs  = vs;
		cam.pix = pix;
	endtask

	task automatic send_vsync();
		repeat (2) drive_cam(1'b0, 1'b0, 1'b1, '0);
		repeat (2) drive_cam(1'b0, 1'b0, 1'b0, '0);
	endtask

	// Each frame opens with vsync, a closing vsync marks the last one done
	task automatic send_frames(input int count);
		vdma_pkg::pixel_group_t grp;
		for (int f = 0; f < count; f++)
		begin
			send_vsync();
			for (int ln = 0; ln < `VDMA_V_ACTIVE; ln++)
			begin
				repeat (2) drive_cam(1'b0, 1'b1, 1'b0, '0);
				drive_cam(1'b0, 1'b0, 1'b0, '0);
				for (int px = 0; px < `VDMA_H_ACTIVE; px++)
				begin
					grp = random_group();
					// Beats past a full buffer are lost
					if (exp_q.size() < `VDMA_FIFO_DEPTH)
						exp_q.push_back(grp);
					drive_cam(1'b1, 1'b0, 1'b0, grp);
				end
				drive_cam(1'b0, 1'b0, 1'b0, '0);
			end
		end
		send_vsync();
	endtask

	//////////////////////////////////////////////////////////////////////
	// Output monitor, disp is registered so it is steady at the falling edge

	// Display syncs from the line and frame layout, two registers behind reset release
	function automatic vdma_pkg::video_t expected_syncs(input int unsigned clks);
		vdma_pkg::video_t v;
		int unsigned      h;
		int unsigned      ln;
		v = '0;
		if (clks >= 2)
		begin
			h    = (clks - 2) % LINE_CLKS;
			ln   = ((clks - 2) / LINE_CLKS) % FRAME_LINES;
			v.hs = (h < `VDMA_H_SYNC);
			v.vs = (ln < `VDMA_V_SYNC);
			v.de = (h >= H_DE_FIRST) && (h < H_DE_FIRST + `VDMA_H_ACTIVE)
				&& (ln >= V_DE_FIRST) && (ln < V_DE_FIRST + `VDMA_V_ACTIVE);
		end
		return v;
	endfunction

	always @(negedge io_systemClk)
	begin
		sync_exp = expected_syncs(clks_since_reset);
		check_bit("disp.de", sync_exp.de, disp.de);
		check_bit("disp.hs", sync_exp.hs, disp.hs);
		check_bit("disp.vs", sync_exp.vs, disp.vs);
		if (arst_n && disp.de && disp.pix != '0)
		begin
			if (exp_q.size() == 0)
			begin
				$display("Error at %0t ns: display showed pixels that were never captured",
					$time);
				end_with_failure();
			end
			else
				check_pixels("disp.pix", exp_q.pop_front(), disp.pix);
		end
	end

	initial
	begin
		wait (rows_loaded);
		#(rows.size() * FRAME_CLKS * 3 * CLK_PERIOD);
		$display("Error: timeout, the stimulus table did not finish in time");
		end_with_failure();
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus table

	task automatic add_row(input op_t op, input logic [15:0] offset, input logic [31:0] data,
		input logic [31:0] exp, input logic exp_err, input logic exp_irq);
		rows.push_back(row_t'{op, offset, data, exp, exp_err, exp_irq});
	endtask

	task automatic load_rows();
		add_row(APB_RD, `VDMA_REG_CTRL, 0, 32'h0, 1'b0, 1'b0);
		add_row(APB_RD, `VDMA_REG_STATUS, 0, 32'h0, 1'b0, 1'b0);
		add_row(APB_RD, `VDMA_REG_IRQ, 0, 32'h0, 1'b0, 1'b0);
		add_row(APB_RD, `VDMA_REG_IRQ_EN, 0, 32'h0, 1'b0, 1'b0);
		// Only the defined bits stick, capture gets armed
		add_row(APB_WR, `VDMA_REG_CTRL, 32'hFFFF_FFFD, 32'h0, 1'b0, 1'b0);
		add_row(APB_RD, `VDMA_REG_CTRL, 0, 32'h1, 1'b0, 1'b0);
		add_row(APB_WR, `VDMA_REG_IRQ_EN, 32'h7, 32'h0, 1'b0, 1'b0);
		add_row(APB_RD, `VDMA_REG_IRQ_EN, 0, 32'h7, 1'b0, 1'b0);
		add_row(APB_WR, `VDMA_REG_IRQ_EN, 32'h0, 32'h0, 1'b0, 1'b0);
		add_row(APB_RD, 16'h0010, 0, 32'h0, 1'b1, 1'b0);
		add_row(APB_WR, 16'h0010, 32'hFFFF_FFFF, 32'h0, 1'b1, 1'b0);
		add_row(APB_RD, `VDMA_REG_CTRL, 0, 32'h1, 1'b0, 1'b0);
		add_row(APB_RD, `VDMA_REG_STATUS, 0, 32'h1, 1'b0, 1'b0);
		// One frame captured
		add_row(CAM_FRAMES, 0, 1, 32'h0, 1'b0, 1'b0);
		add_row(APB_RD, `VDMA_REG_IRQ, 0, 32'h1, 1'b0, 1'b0);
		add_row(APB_RD, `VDMA_REG_STATUS, 0, 32'h102, 1'b0, 1'b0);
		add_row(APB_WR, `VDMA_REG_IRQ_EN, 32'h1, 32'h0, 1'b0, 1'b1);
		add_row(APB_WR, `VDMA_REG_IRQ_EN, 32'h6, 32'h0, 1'b0, 1'b0);
		add_row(APB_WR, `VDMA_REG_IRQ, 32'h1, 32'h0, 1'b0, 1'b0);
		add_row(APB_RD, `VDMA_REG_IRQ, 0, 32'h0, 1'b0, 1'b0);
		// Loopback, then underflow on the empty buffer
		add_row(APB_WR, `VDMA_REG_CTRL, 32'h3, 32'h0, 1'b0, 1'b0);
		add_row(IDLE_FRAMES, 0, 3, 32'd0, 1'b0, 1'b1);
		add_row(APB_RD, `VDMA_REG_IRQ, 0, 32'h4, 1'b0, 1'b1);
		add_row(APB_WR, `VDMA_REG_CTRL, 32'h1, 32'h0, 1'b0, 1'b1);
		add_row(IDLE_FRAMES, 0, 1, 32'd0, 1'b0, 1'b1);
		add_row(APB_WR, `VDMA_REG_IRQ, 32'h7, 32'h0, 1'b0, 1'b0);
		add_row(APB_RD, `VDMA_REG_IRQ, 0, 32'h0, 1'b0, 1'b0);
		// Two frames into a one frame buffer
		add_row(CAM_FRAMES, 0, 2, 32'h0, 1'b0, 1'b1);
		add_row(IDLE_FRAMES, 0, 1, 32'd16, 1'b0, 1'b1);
		add_row(APB_RD, `VDMA_REG_IRQ, 0, 32'h3, 1'b0, 1'b1);
		add_row(APB_RD, `VDMA_REG_STATUS, 0, 32'h402, 1'b0, 1'b1);
		add_row(APB_WR, `VDMA_REG_CTRL, 32'h2, 32'h0, 1'b0, 1'b1);
		add_row(IDLE_FRAMES, 0, 3, 32'd0, 1'b0, 1'b1);
		add_row(APB_RD, `VDMA_REG_IRQ, 0, 32'h7, 1'b0, 1'b1);
		add_row(APB_WR, `VDMA_REG_CTRL, 32'h0, 32'h0, 1'b0, 1'b1);
		add_row(IDLE_FRAMES, 0, 1, 32'd0, 1'b0, 1'b1);
		add_row(APB_WR, `VDMA_REG_IRQ, 32'h7, 32'h0, 1'b0, 1'b0);
		add_row(APB_RD, `VDMA_REG_IRQ, 0, 32'h0, 1'b0, 1'b0);
		add_row(APB_RD, `VDMA_REG_STATUS, 0, 32'h402, 1'b0, 1'b0);
	endtask

	task automatic run_row(input row_t r);
		case (r.op)
			APB_WR:      write_reg(r.offset, r.data, r.exp_err);
			APB_RD:      read_reg(r.offset, r.exp, r.exp_err);
			CAM_FRAMES:  send_frames(r.data);
			IDLE_FRAMES:
			begin
				repeat (r.data * FRAME_CLKS) @(negedge io_systemClk);
				check_word("pending pixel groups", r.exp, exp_q.size());
			end
		endcase
		@(negedge io_systemClk);
		#(CLK_PERIOD / 4);
		check_bit("dma_irq", r.exp_irq, dma_irq);
	endtask

	initial
	begin
		io_systemClk = 1'b0;
		arst_n       = 1'b0;
		apb_req      = '0;
		cam          = '0;
		rows_loaded  = 1'b0;
		void'($urandom(32'hccb9));
		load_rows();
		rows_loaded = 1'b1;

		repeat (10)
		begin
			@(negedge io_systemClk);
			check_bit("disp.de", 1'b0, disp.de);
			check_bit("dma_irq", 1'b0, dma_irq);
		end
		arst_n = 1'b1;

		foreach (rows[i])
			run_row(rows[i]);

		if (exp_q.size() == 0)
		begin
			$display("ALL TESTS PASSED");
			$finish;
		end
		else
		begin
			$display("Error: %0d captured pixel groups were never displayed", exp_q.size());
			end_with_failure();
		end
	end

endmodule

/* logic/beat_fifo.sv */
// Show-ahead buffer. A push while full is dropped, and a pop while empty is ignored
`timescale 1ns/1ps
`include "vdma_macros.svh"

module beat_fifo (
	input  logic                   io_systemClk,
	input  logic                   arst_n,
	input  logic                   push,
	input  vdma_pkg::stream_beat_t push_beat,
	input  logic                   pop,
	output vdma_pkg::stream_beat_t head,
	output logic                   empty,
	output logic                   overflow
);

	vdma_pkg::stream_beat_t   mem [`VDMA_FIFO_DEPTH];
	logic [`VDMA_FIFO_AW-1:0] wr_ptr;
	logic [`VDMA_FIFO_AW-1:0] rd_ptr;
	logic [`VDMA_FIFO_AW:0]   count;
	logic                     full;
	logic                     do_push;
	logic                     do_pop;

	assign full    = (count == `VDMA_FIFO_DEPTH);
	assign empty   = (count == '0);
	assign do_push = push & ~full;
	assign do_pop  = pop & ~empty;
	assign head    = mem[rd_ptr];

	always_ff @(posedge io_systemClk)
	begin
		if (do_push)
			mem[wr_ptr] <= push_beat;
	end

	// Pointers wrap on their own since depth is a power of two
	always_ff @(posedge io_systemClk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			overflow <= push & full; // one clock per lost beat
		end
	end

endmodule

/* logic/stream_in_packer.sv */
// No back-pressure toward the camera. A beat leaves one clock after its gated de clock
`timescale 1ns/1ps

module stream_in_packer (
	input  logic                   io_systemClk,
	input  logic                   arst_n,
	input  logic                   cap_gate,
	input  vdma_pkg::video_t       cam,
	output logic                   push,
	output vdma_pkg::stream_beat_t beat
);

	vdma_pkg::pixel_group_t pix_q;
	logic                   de_q;
	logic                   vs_q;
	logic                   vs_seen;

	// Pixel copy one clock behind the camera
	always_ff @(posedge io_systemClk)
	begin
		pix_q <= cam.pix;
	end

	always_ff @(posedge io_systemClk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			de_q    <= 1'b0;
			vs_q    <= 1'b0;
			vs_seen <= 1'b0;
		end
		else
		begin
			de_q <= cam.de & cap_gate;
			vs_q <= cam.vs;
			// Armed by a vsync edge until the next beat goes out
			if (cam.vs && !vs_q)
				vs_seen <= 1'b1;
			else if (de_q)
				vs_seen <= 1'b0;
		end
	end

	assign push = de_q;

	// Line ends when the camera de has already dropped
	always_comb
	begin
		beat.pix = pix_q;
		beat.sof = vs_seen;
		beat.eol = ~cam.de;
	end

endmodule

/* logic/stream_out_aligner.sv */
// Output lags the timing generator by one clock. Black is shown whenever no beat is popped
`timescale 1ns/1ps
`include "vdma_macros.svh"

module stream_out_aligner (
	input  logic                   io_systemClk,
	input  logic                   arst_n,
	input  logic                   play_gate,
	input  vdma_pkg::video_t       timing,
	input  vdma_pkg::stream_beat_t head,
	input  logic                   empty,
	output logic                   pop,
	output logic                   underflow,
	output vdma_pkg::video_t       disp
);

	localparam vdma_pkg::pixel_group_t BLACK = {(`VDMA_PIX_W * `VDMA_PIX_PER_CLK){1'b0}};

	logic             active;
	vdma_pkg::video_t disp_d;

	//////////////////////////////////////////////////////////////////////
	// Pop decision on each active clock of the playback frame
	assign active    = timing.de & play_gate;
	assign pop       = active & ~empty;
	assign underflow = active & empty;

	always_comb
	begin
		disp_d.de  = timing.de;
		disp_d.hs  = timing.hs;
		disp_d.vs  = timing.vs;
		disp_d.pix = pop ? head.pix : BLACK;
	end

	// Syncs and pixels move together so they stay aligned
	always_ff @(posedge io_systemClk or negedge arst_n)
	begin
		if (!arst_n)
			disp <= '0;
		else
			disp <= disp_d;
	end

endmodule

/* logic/vdma_ctrl_regs.sv */
// APB is zero wait state. Unknown offsets answer pslverr. Both vsync inputs must be in this clock
`timescale 1ns/1ps
`include "vdma_macros.svh"

module vdma_ctrl_regs (
	input  logic               io_systemClk,
	input  logic               arst_n,
	input  vdma_pkg::apb_req_t apb_req,
	output vdma_pkg::apb_rsp_t apb_rsp,
	input  logic               cam_vs,
	input  logic               timing_vs,
	input  logic               overflow,
	input  logic               underflow,
	output logic               cap_gate,
	output logic               play_gate,
	output logic               dma_irq
);

	logic [1:0]             ctrl_q;
	vdma_pkg::irq_bits_t    irq_q;
	vdma_pkg::irq_bits_t    irq_en_q;
	vdma_pkg::irq_bits_t    irq_set;
	vdma_pkg::irq_bits_t    irq_clr;
	logic [7:0]             frame_cnt_q;
	vdma_pkg::cap_state_t   cap_state;
	vdma_pkg::play_state_t  play_state;
	logic                   cam_vs_q;
	logic                   timing_vs_q;
	logic                   cam_vs_rise;
	logic                   timing_vs_rise;
	logic                   access;
	logic                   hit;
	logic                   wr_en;
	logic [31:0]            rd_word;
	logic                   frame_done;

	//////////////////////////////////////////////////////////////////////
	// APB decode
	assign access = apb_req.psel & apb_req.penable;
	assign wr_en  = access & apb_req.pwrite & hit;

	always_comb
	begin
		hit     = 1'b1;
		rd_word = '0;
		case (apb_req.paddr)
			`VDMA_REG_CTRL:   rd_word = {30'd0, ctrl_q};
			`VDMA_REG_STATUS: rd_word = {16'd0, frame_cnt_q, 4'd0, play_state, cap_state};
			`VDMA_REG_IRQ:    rd_word = {29'd0, irq_q};
			`VDMA_REG_IRQ_EN: rd_word = {29'd0, irq_en_q};
			default:          hit = 1'b0;
		endcase
	end

	assign apb_rsp.pready  = 1'b1;
	assign apb_rsp.pslverr = access & ~hit;
	assign apb_rsp.prdata  = (access & ~apb_req.pwrite) ? rd_word : 32'd0;

	always_ff @(posedge io_systemClk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			ctrl_q   <= '0;
			irq_en_q <= '0;
		end
		else if (wr_en)
		begin
			if (apb_req.paddr == `VDMA_REG_CTRL)
				ctrl_q <= apb_req.pwdata[1:0];
			if (apb_req.paddr == `VDMA_REG_IRQ_EN)
				irq_en_q <= vdma_pkg::irq_bits_t'(apb_req.pwdata[2:0]);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Interrupts, new events win over a write-one clear
	assign frame_done = (cap_state == vdma_pkg::CAP_RUN) & cam_vs_rise;

	always_comb
	begin
		irq_set.frame_done = frame_done;
		irq_set.overflow   = overflow;
		irq_set.underflow  = underflow;
		irq_clr = '0;
		if (wr_en && apb_req.paddr == `VDMA_REG_IRQ)
			irq_clr = vdma_pkg::irq_bits_t'(apb_req.pwdata[2:0]);
	end

	assign dma_irq = |(irq_q & irq_en_q);

	always_ff @(posedge io_systemClk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			irq_q       <= '0;
			frame_cnt_q <= '0;
			cam_vs_q    <= 1'b0;
			timing_vs_q <= 1'b0;
		end
		else
		begin
			irq_q       <= vdma_pkg::irq_bits_t'((irq_q & ~irq_clr) | irq_set);
			cam_vs_q    <= cam_vs;
			timing_vs_q <= timing_vs;
			if (frame_done)
				frame_cnt_q <= frame_cnt_q + 8'd1;
		end
	end

	assign cam_vs_rise    = cam_vs & ~cam_vs_q;
	assign timing_vs_rise = timing_vs & ~timing_vs_q;

	//////////////////////////////////////////////////////////////////////
	// Capture and playback sequencing, both step on vsync edges
	always_ff @(posedge io_systemClk or negedge arst_n)
	begin
		if (!arst_n)
			cap_state <= vdma_pkg::CAP_IDLE;
		else
			case (cap_state)
				vdma_pkg::CAP_IDLE:
					if (ctrl_q[0])
						cap_state <= vdma_pkg::CAP_ARMED;
				vdma_pkg::CAP_ARMED:
					if (cam_vs_rise)
						cap_state <= ctrl_q[0] ? vdma_pkg::CAP_RUN : vdma_pkg::CAP_IDLE;
				vdma_pkg::CAP_RUN:
					if (cam_vs_rise && !ctrl_q[0])
						cap_state <= vdma_pkg::CAP_IDLE;
				default:
					cap_state <= vdma_pkg::CAP_IDLE;
			endcase
	end

	always_ff @(posedge io_systemClk or negedge arst_n)
	begin
		if (!arst_n)
			play_state <= vdma_pkg::PLAY_OFF;
		else
			case (play_state)
				vdma_pkg::PLAY_OFF:
					if (ctrl_q[1])
						play_state <= vdma_pkg::PLAY_WAIT;
				vdma_pkg::PLAY_WAIT:
					if (timing_vs_rise)
						play_state <= ctrl_q[1] ? vdma_pkg::PLAY_ON : vdma_pkg::PLAY_OFF;
				vdma_pkg::PLAY_ON:
					if (timing_vs_rise && !ctrl_q[1])
						play_state <= vdma_pkg::PLAY_OFF;
				default:
					play_state <= vdma_pkg::PLAY_OFF;
			endcase
	end

	assign cap_gate  = (cap_state == vdma_pkg::CAP_RUN);
	assign play_gate = (play_state == vdma_pkg::PLAY_ON);

endmodule

/* logic/vdma_macros.svh */
// Sizes are fixed for a small test frame. VDMA_FIFO_DEPTH must equal 2**VDMA_FIFO_AW
`ifndef VDMA_MACROS_SVH
`define VDMA_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// Pixel format
`define VDMA_PIX_W        8
`define VDMA_PIX_PER_CLK  4

// Horizontal timing in clocks, four pixels per clock
`define VDMA_H_ACTIVE     4
`define VDMA_H_SYNC       2
`define VDMA_H_BP         2
`define VDMA_H_FP         2

// Vertical timing in lines
`define VDMA_V_ACTIVE     4
`define VDMA_V_SYNC       1
`define VDMA_V_BP         1
`define VDMA_V_FP         1

//////////////////////////////////////////////////////////////////////
// Beat buffer holds exactly one frame
`define VDMA_FIFO_DEPTH   16
`define VDMA_FIFO_AW      4

// APB register offsets
`define VDMA_REG_CTRL     16'h0000
`define VDMA_REG_STATUS   16'h0004
`define VDMA_REG_IRQ      16'h0008
`define VDMA_REG_IRQ_EN   16'h000C

`endif

/* logic/vdma_pkg.sv */
// Types only. The pixel group is fixed at four pixels of VDMA_PIX_W bits each
`include "vdma_macros.svh"

package vdma_pkg;

	// Four pixels that arrive on the same clock
	typedef struct packed {
		logic [`VDMA_PIX_W-1:0] rd_00;
		logic [`VDMA_PIX_W-1:0] rd_01;
		logic [`VDMA_PIX_W-1:0] rd_10;
		logic [`VDMA_PIX_W-1:0] rd_11;
	} pixel_group_t;

	// One buffer entry with its frame and line marks
	typedef struct packed {
		pixel_group_t pix;
		logic         sof;
		logic         eol;
	} stream_beat_t;

	// Camera input and display output share this layout
	typedef struct packed {
		logic         de;
		logic         hs;
		logic         vs;
		pixel_group_t pix;
	} video_t;

	typedef struct packed {
		logic [15:0] paddr;
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

	// frame_done sits in bit 0
	typedef struct packed {
		logic underflow;
		logic overflow;
		logic frame_done;
	} irq_bits_t;

	typedef enum logic [1:0] {CAP_IDLE, CAP_ARMED, CAP_RUN} cap_state_t;

	typedef enum logic [1:0] {PLAY_OFF, PLAY_WAIT, PLAY_ON} play_state_t;

endpackage

/* logic/vdma_stream_top.sv */
// Single clock for APB, camera and display. The buffer holds one frame in place of memory
`timescale 1ns/1ps

module vdma_stream_top (
	input  logic               io_systemClk,
	input  logic               arst_n,
	input  vdma_pkg::apb_req_t apb_req,
	output vdma_pkg::apb_rsp_t apb_rsp,
	input  vdma_pkg::video_t   cam,
	output vdma_pkg::video_t   disp,
	output logic               dma_irq
);

	logic                   cap_gate;
	logic                   play_gate;
	logic                   push;
	logic                   pop;
	logic                   empty;
	logic                   overflow;
	logic                   underflow;
	vdma_pkg::stream_beat_t beat;
	vdma_pkg::stream_beat_t head;
	vdma_pkg::video_t       timing;

	//////////////////////////////////////////////////////////////////////
	// Control and playback timing
	vdma_ctrl_regs inst_ctrl_regs (
		.io_systemClk (io_systemClk),
		.arst_n       (arst_n),
		.apb_req      (apb_req),
		.apb_rsp      (apb_rsp),
		.cam_vs       (cam.vs),
		.timing_vs    (timing.vs),
		.overflow     (overflow),
		.underflow    (underflow),
		.cap_gate     (cap_gate),
		.play_gate    (play_gate),
		.dma_irq      (dma_irq)
	);

	video_timing_gen inst_timing_gen (
		.io_systemClk (io_systemClk),
		.arst_n       (arst_n),
		.timing       (timing)
	);

	//////////////////////////////////////////////////////////////////////
	// Camera to buffer to display
	stream_in_packer inst_packer (
		.io_systemClk (io_systemClk),
		.arst_n       (arst_n),
		.cap_gate     (cap_gate),
		.cam          (cam),
		.push         (push),
		.beat         (beat)
	);

	beat_fifo inst_beat_fifo (
		.io_systemClk (io_systemClk),
		.arst_n       (arst_n),
		.push         (push),
		.push_beat    (beat),
		.pop          (pop),
		.head         (head),
		.empty        (empty),
		.overflow     (overflow)
	);

	stream_out_aligner inst_aligner (
		.io_systemClk (io_systemClk),
		.arst_n       (arst_n),
		.play_gate    (play_gate),
		.timing       (timing),
		.head         (head),
		.empty        (empty),
		.pop          (pop),
		.underflow    (underflow),
		.disp         (disp)
	);

endmodule

/* logic/video_timing_gen.sv */
// Free running from reset with active high syncs. Counter widths fit only the small macro frame
`timescale 1ns/1ps
`include "vdma_macros.svh"

module video_timing_gen (
	input  logic             io_systemClk,
	input  logic             arst_n,
	output vdma_pkg::video_t timing
);

	// Line is sync, back porch, active, front porch
	localparam logic [3:0] H_SYNC_END = 4'(`VDMA_H_SYNC);
	localparam logic [3:0] H_DE_START = 4'(`VDMA_H_SYNC + `VDMA_H_BP);
	localparam logic [3:0] H_DE_END   = 4'(`VDMA_H_SYNC + `VDMA_H_BP + `VDMA_H_ACTIVE);
	localparam logic [3:0] H_LAST     = 4'(`VDMA_H_SYNC + `VDMA_H_BP + `VDMA_H_ACTIVE
		+ `VDMA_H_FP - 1);

	localparam logic [2:0] V_SYNC_END = 3'(`VDMA_V_SYNC);
	localparam logic [2:0] V_DE_START = 3'(`VDMA_V_SYNC + `VDMA_V_BP);
	localparam logic [2:0] V_DE_END   = 3'(`VDMA_V_SYNC + `VDMA_V_BP + `VDMA_V_ACTIVE);
	localparam logic [2:0] V_LAST     = 3'(`VDMA_V_SYNC + `VDMA_V_BP + `VDMA_V_ACTIVE
		+ `VDMA_V_FP - 1);

	logic [3:0] h_cnt;
	logic [2:0] v_cnt;
	logic       h_act;
	logic       v_act;
	logic       de_q;
	logic       hs_q;
	logic       vs_q;

	always_ff @(posedge io_systemClk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			h_cnt <= '0;
			v_cnt <= '0;
		end
		else if (h_cnt == H_LAST)
		begin
			h_cnt <= '0;
			if (v_cnt == V_LAST)
				v_cnt <= '0;
			else
				v_cnt <= v_cnt + 3'd1;
		end
		else
			h_cnt <= h_cnt + 4'd1;
	end

	assign h_act = (h_cnt >= H_DE_START) && (h_cnt < H_DE_END);
	assign v_act = (v_cnt >= V_DE_START) && (v_cnt < V_DE_END);

	// Registered syncs so vs rises one clock after the frame wraps
	always_ff @(posedge io_systemClk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			de_q <= 1'b0;
			hs_q <= 1'b0;
			vs_q <= 1'b0;
		end
		else
		begin
			de_q <= h_act & v_act;
			hs_q <= (h_cnt < H_SYNC_END);
			vs_q <= (v_cnt < V_SYNC_END);
		end
	end

	always_comb
	begin
		timing.de  = de_q;
		timing.hs  = hs_q;
		timing.vs  = vs_q;
		timing.pix = '0;
	end

endmodule
